//--- dv/spi_mem_chk.sv
`timescale 1ns/10ps

module spi_mem_chk
(
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input logic err,
    input logic cs
);
    int fail_count;

    initial
    begin
        fail_count = 0;
    end

    //////////////////////////////
    // Control outputs
    //////////////////////////////

    // Error flag only rides on a completion
    err_with_done: assert property (@(posedge clk) disable iff (rst) err |-> done)
    else
    begin
        $error("err is high outside a done cycle");
        fail_count++;
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else
    begin
        $error("done stayed high for more than one cycle");
        fail_count++;
    end

    // Link stays deselected between transfers
    cs_idle_high: assert property (@(posedge clk) disable iff (rst) !busy |-> cs)
    else
    begin
        $error("cs is low while busy is low");
        fail_count++;
    end

endmodule

bind spi_mem_top spi_mem_chk chk_i
(
    .clk  (clk),
    .rst  (rst),
    .busy (busy),
    .done (done),
    .err  (err),
    .cs   (cs)
);

//--- dv/spi_mem_monitor.sv
`timescale 1ns/10ps

module spi_mem_monitor
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  spi_mem_pkg::spi_req_t          req,
    input  logic                           busy,
    input  logic                           done,
    input  logic                           err,
    input  logic [spi_mem_pkg::data_w-1:0] rdata,
    output int                             check_count,
    output int                             error_count
);
    import spi_mem_pkg::*;

    logic [data_w-1:0] model_mem [mem_depth];
    logic [data_w-1:0] model_rdata;
    spi_req_t          pend_req [$];
    int                pend_cyc [$];
    int                cyc;

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    //////////////////////////////
    // Completion compare
    //////////////////////////////

    task automatic compare_op(input spi_req_t r, input int accept_cyc);
        logic bad;
        bad = (r.addr >= addr_w'(mem_depth));
        check_count++;
        if (err !== bad)
        begin
            report_error($sformatf("err is %0b for addr %0d, expected %0b", err, r.addr, bad));
        end
        // Rejected address completes 3 cycles after the accepting edge
        if (bad && (cyc - accept_cyc) != 3)
        begin
            report_error($sformatf("bad address done after %0d cycles, expected 3",
                                   cyc - accept_cyc));
        end
        if (!bad && r.wr)
        begin
            model_mem[r.addr[mem_aw-1:0]] = r.din;
        end
        else if (!bad)
        begin
            model_rdata = model_mem[r.addr[mem_aw-1:0]];
        end
        if (rdata !== model_rdata)
        begin
            report_error($sformatf("rdata %02h after %s of addr %0d, expected %02h",
                                   rdata, r.wr ? "write" : "read", r.addr, model_rdata));
        end
    endtask

    //////////////////////////////
    // Watch the top level
    //////////////////////////////

    always @(posedge clk)
    begin
        cyc++;
        if (rst)
        begin
            pend_req.delete();
            pend_cyc.delete();
            check_count = 0;
            error_count = 0;
            cyc         = 0;
            model_rdata = '0;
            for (int i = 0; i < mem_depth; i++)
            begin
                model_mem[i] = '0;
            end
        end
        else
        begin
            if (pend_req.size() == 0 && busy !== 1'b0)
            begin
                report_failure("busy is high with no request in flight");
            end
            else if (pend_req.size() != 0 && !done && busy !== 1'b1)
            begin
                report_error($sformatf("busy is %b with a request in flight, expected 1",
                                       busy));
            end
            // Held byte moves only on a done cycle
            if (!done && rdata !== model_rdata)
            begin
                report_error($sformatf("rdata %02h between completions, expected %02h",
                                       rdata, model_rdata));
            end
            if (done && pend_req.size() == 0)
            begin
                report_failure("done pulsed with no request in flight");
            end
            else if (done)
            begin
                compare_op(pend_req.pop_front(), pend_cyc.pop_front());
            end
            if (start && !busy)
            begin
                pend_req.push_back(req);
                pend_cyc.push_back(cyc);
            end
        end
    end

endmodule

//--- dv/spi_mem_tb.sv
`timescale 1ns/10ps

module spi_mem_tb;
    import spi_mem_pkg::*;

    localparam int max_ops    = 300;
    localparam int max_cycles = max_ops * 40 + 16;

    logic              clk;
    logic              rst;
    logic              start;
    spi_req_t          req;
    logic              busy;
    logic              done;
    logic              err;
    logic [data_w-1:0] rdata;
    logic [15:0]       lfsr;
    int                check_count;
    int                error_count;
    int                ops_issued;
    int                cycle_cnt;

    spi_mem_top dut_i
    (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .err   (err),
        .rdata (rdata)
    );

    spi_mem_monitor mon_i
    (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .req         (req),
        .busy        (busy),
        .done        (done),
        .err         (err),
        .rdata       (rdata),
        .check_count (check_count),
        .error_count (error_count)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val[i] = lfsr[0];
            lfsr   = lfsr_step(lfsr);
        end
        return val;
    endfunction

    function automatic logic [addr_w-1:0] bad_addr_from(input logic [7:0] raw);
        return (raw < 8'd32) ? raw + 8'd32 : raw;
    endfunction

    // Drop mode also fires a neighbour address write mid transfer
    task automatic run_op(input logic wr, input logic [addr_w-1:0] addr,
                          input logic [data_w-1:0] din, input logic drop);
        @(posedge clk);
        start <= 1'b1;
        req   <= '{wr: wr, addr: addr, din: din};
        ops_issued++;
        @(posedge clk);
        start <= 1'b0;
        if (drop)
        begin
            repeat (4) @(posedge clk);
            start <= 1'b1;
            req   <= '{wr: 1'b1, addr: addr ^ 8'd1, din: ~din};
            @(posedge clk);
            start <= 1'b0;
        end
        do
        begin
            @(posedge clk);
        end
        while (done !== 1'b1);
    endtask

    task automatic end_phase(input string name);
        $display("Test %s finished: %0d ops checked, %0d errors", name, check_count,
                 error_count);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        logic [15:0]       tmp;
        logic [addr_w-1:0] addr;
        logic [2:0]        sel;
        logic              wr;
        int                gap;
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        req        = '0;
        lfsr       = 16'd21;
        ops_issued = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (8) @(posedge clk);
        end_phase("reset_idle");

        // Never written yet, so these read back zero
        run_op(1'b0, 8'd3, 8'h00, 1'b0);
        run_op(1'b0, 8'd10, 8'h00, 1'b0);
        run_op(1'b0, 8'd31, 8'h00, 1'b0);
        run_op(1'b0, 8'd0, 8'h00, 1'b0);
        for (int a = 0; a < mem_depth; a++)
        begin
            run_op(1'b1, addr_w'(a), data_w'(rand_bits(8)), 1'b0);
        end
        for (int a = 0; a < mem_depth; a++)
        begin
            run_op(1'b0, addr_w'(a), 8'h00, 1'b0);
        end
        end_phase("fill_and_read");

        // Each rejected address is followed by a read of its low five bit alias
        run_op(1'b1, 8'd32, 8'hA5, 1'b0);
        run_op(1'b0, 8'd0, 8'h00, 1'b0);
        run_op(1'b0, 8'd255, 8'h00, 1'b0);
        run_op(1'b0, 8'd31, 8'h00, 1'b0);
        for (int i = 0; i < 6; i++)
        begin
            tmp = rand_bits(9);
            run_op(tmp[8], bad_addr_from(tmp[7:0]), data_w'(rand_bits(8)), 1'b0);
            run_op(1'b0, addr_w'(tmp[mem_aw-1:0]), 8'h00, 1'b0);
        end
        end_phase("bad_addr");

        run_op(1'b1, 8'd8, 8'h3C, 1'b1);
        run_op(1'b0, 8'd20, 8'h00, 1'b1);
        run_op(1'b1, 8'd14, 8'h5A, 1'b1);
        run_op(1'b0, 8'd26, 8'h00, 1'b1);
        run_op(1'b0, 8'd9, 8'h00, 1'b0);
        run_op(1'b0, 8'd21, 8'h00, 1'b0);
        run_op(1'b0, 8'd15, 8'h00, 1'b0);
        run_op(1'b0, 8'd27, 8'h00, 1'b0);
        end_phase("busy_drop");

        for (int n = 0; n < 200; n++)
        begin
            sel = 3'(rand_bits(3));
            tmp = rand_bits(8);
            if (sel >= 3'd6)
            begin
                addr = bad_addr_from(tmp[7:0]);
                wr   = 1'(rand_bits(1));
            end
            else
            begin
                addr = addr_w'(tmp[mem_aw-1:0]);
                wr   = (sel < 3'd3);
            end
            gap = int'(rand_bits(2));
            repeat (gap) @(posedge clk);
            run_op(wr, addr, data_w'(rand_bits(8)), 1'b0);
        end
        end_phase("random_mix");

        repeat (4) @(posedge clk);
        $display("Totals: %0d of %0d ops checked, %0d errors, %0d assertion failures",
                 check_count, ops_issued, error_count, dut_i.chk_i.fail_count);
        if (error_count == 0 && dut_i.chk_i.fail_count == 0 && check_count == ops_issued)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Run limit sized from the op budget
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", max_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- hdl/spi_master_shift.sv
`timescale 1ns/10ps

module spi_master_shift
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_valid,
    input  spi_mem_pkg::spi_frame_t frame,
    input  logic                    bad_addr,
    input  logic                    miso,
    input  logic                    ready,
    input  logic                    op_done,
    output logic                    busy,
    output logic                    cs,
    output logic                    mosi,
    output logic                    xfer_end,
    output spi_mem_pkg::spi_resp_t  resp
);
    import spi_mem_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_send,
        st_wait_store,
        st_wait_ready,
        st_receive
    } state_t;

    state_t            state;
    spi_frame_t        frame_q;
    logic [cnt_w-1:0]  bit_cnt;
    logic [cnt_w-1:0]  send_len;
    logic [data_w-1:0] rx_sr;
    logic              busy_q;

    // Writes send the whole frame, reads stop after the address
    assign send_len = frame_q.wr ? cnt_w'(frame_w) : cnt_w'(rd_frame_w);

    // Covers the request cycle too, so a second start is refused at once
    assign busy = busy_q | frame_valid | bad_addr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q <= 1'b0;
        end
        else if (frame_valid || bad_addr)
        begin
            busy_q <= 1'b1;
        end
        else if (xfer_end)
        begin
            busy_q <= 1'b0;
        end
    end

    //////////////////////////////
    // Link FSM
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= st_idle;
            bit_cnt  <= '0;
            cs       <= 1'b1;
            mosi     <= 1'b0;
            xfer_end <= 1'b0;
        end
        else
        begin
            xfer_end <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (frame_valid)
                    begin
                        // First bit goes straight from the incoming frame
                        cs      <= 1'b0;
                        mosi    <= frame.wr;
                        bit_cnt <= cnt_w'(1);
                        state   <= st_send;
                    end
                    else if (bad_addr)
                    begin
                        xfer_end <= 1'b1;
                    end
                end

                st_send:
                begin
                    if (bit_cnt < send_len)
                    begin
                        mosi    <= frame_q[bit_cnt];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    else
                    begin
                        cs      <= 1'b1;
                        mosi    <= 1'b0;
                        bit_cnt <= '0;
                        state   <= frame_q.wr ? st_wait_store : st_wait_ready;
                    end
                end

                st_wait_store:
                begin
                    if (op_done)
                    begin
                        xfer_end <= 1'b1;
                        state    <= st_idle;
                    end
                end

                st_wait_ready:
                begin
                    if (ready)
                    begin
                        bit_cnt <= '0;
                        state   <= st_receive;
                    end
                end

                st_receive:
                begin
                    if (bit_cnt == cnt_w'(data_w - 1))
                    begin
                        bit_cnt  <= '0;
                        xfer_end <= 1'b1;
                        state    <= st_idle;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // Payload
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (state == st_idle && frame_valid)
        begin
            frame_q <= frame;
        end

        // Read byte arrives LSB first
        if (state == st_receive)
        begin
            rx_sr <= {miso, rx_sr[data_w-1:1]};
        end

        if (state == st_idle && bad_addr)
        begin
            resp <= '{rd: 1'b0, err: 1'b1, rdata: rx_sr};
        end
        else if (state == st_wait_store && op_done)
        begin
            resp <= '{rd: 1'b0, err: 1'b0, rdata: rx_sr};
        end
        else if (state == st_receive && bit_cnt == cnt_w'(data_w - 1))
        begin
            resp <= '{rd: 1'b1, err: 1'b0, rdata: {miso, rx_sr[data_w-1:1]}};
        end
    end

endmodule

//--- hdl/spi_mem_pkg.sv
package spi_mem_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int data_w     = 8;
    localparam int addr_w     = 8;

    // Legal addresses are below mem_depth
    localparam int mem_depth  = 32;
    localparam int mem_aw     = $clog2(mem_depth);

    // Op bit, address, data
    localparam int frame_w    = 1 + addr_w + data_w;

    // Op bit and address only
    localparam int rd_frame_w = 1 + addr_w;

    // Bit counter wide enough to hold frame_w
    localparam int cnt_w      = $clog2(frame_w + 1);

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef struct packed {
        logic              wr;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] din;
    } spi_req_t;

    // Bit 0 goes out first, so wr leads, then addr and din LSB first
    typedef struct packed {
        logic [data_w-1:0] din;
        logic [addr_w-1:0] addr;
        logic              wr;
    } spi_frame_t;

    // Completion record with rd set for a read transfer
    typedef struct packed {
        logic              rd;
        logic              err;
        logic [data_w-1:0] rdata;
    } spi_resp_t;

endpackage

//--- hdl/spi_mem_slave.sv
`timescale 1ns/10ps

module spi_mem_slave
(
    input  logic clk,
    input  logic rst,
    input  logic cs,
    input  logic mosi,
    output logic miso,
    output logic ready,
    output logic op_done
);
    import spi_mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_collect,
        st_send
    } state_t;

    state_t            state;
    logic [data_w-1:0] mem [mem_depth];
    logic              cs_q;
    logic              cs_fall;
    logic              frame_last;
    logic [cnt_w-1:0]  bit_cnt;
    logic [cnt_w-1:0]  last_bit;
    spi_frame_t        frame_sr;
    spi_frame_t        frame_nxt;
    logic [data_w-1:0] tx_sr;

    assign cs_fall    = !cs && cs_q;
    assign last_bit   = frame_sr.wr ? cnt_w'(frame_w - 1) : cnt_w'(rd_frame_w - 1);
    assign frame_last = (state == st_collect) && !cs && (bit_cnt == last_bit);

    // Frame with the current mosi bit already in place
    always_comb
    begin
        frame_nxt = frame_sr;
        frame_nxt[bit_cnt] = mosi;
    end

    //////////////////////////////
    // Frame decode FSM
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= st_idle;
            cs_q    <= 1'b1;
            bit_cnt <= '0;
            miso    <= 1'b0;
            ready   <= 1'b0;
            op_done <= 1'b0;
        end
        else
        begin
            cs_q    <= cs;
            ready   <= 1'b0;
            op_done <= 1'b0;
            case (state)
                st_idle:
                begin
                    miso <= 1'b0;
                    // Op bit is on mosi in the first low cycle
                    if (cs_fall)
                    begin
                        bit_cnt <= cnt_w'(1);
                        state   <= st_collect;
                    end
                end

                st_collect:
                begin
                    if (cs)
                    begin
                        // Master gave up mid frame
                        bit_cnt <= '0;
                        state   <= st_idle;
                    end
                    else if (frame_last)
                    begin
                        bit_cnt <= '0;
                        if (frame_sr.wr)
                        begin
                            op_done <= 1'b1;
                            state   <= st_idle;
                        end
                        else
                        begin
                            ready <= 1'b1;
                            state <= st_send;
                        end
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                st_send:
                begin
                    if (bit_cnt == cnt_w'(data_w))
                    begin
                        miso    <= 1'b0;
                        bit_cnt <= '0;
                        state   <= st_idle;
                    end
                    else
                    begin
                        miso    <= tx_sr[0];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < mem_depth; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (frame_last && frame_sr.wr)
        begin
            mem[frame_nxt.addr[mem_aw-1:0]] <= frame_nxt.din;
        end
    end

    // Shift registers
    always_ff @(posedge clk)
    begin
        if (state == st_idle && cs_fall)
        begin
            frame_sr <= '{din: '0, addr: '0, wr: mosi};
        end
        else if (state == st_collect)
        begin
            frame_sr <= frame_nxt;
        end

        if (frame_last && !frame_sr.wr)
        begin
            tx_sr <= mem[frame_nxt.addr[mem_aw-1:0]];
        end
        else if (state == st_send)
        begin
            tx_sr <= tx_sr >> 1;
        end
    end

endmodule

//--- hdl/spi_mem_top.sv
`timescale 1ns/10ps

module spi_mem_top
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  spi_mem_pkg::spi_req_t          req,
    output logic                           busy,
    output logic                           done,
    output logic                           err,
    output logic [spi_mem_pkg::data_w-1:0] rdata
);
    import spi_mem_pkg::*;

    // Host side
    logic       frame_valid;
    spi_frame_t frame;
    logic       bad_addr;
    logic       xfer_end;
    spi_resp_t  resp;

    // Serial link
    logic cs;
    logic mosi;
    logic miso;
    logic ready;
    logic op_done;

    spi_req_check req_check_i
    (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .req         (req),
        .busy        (busy),
        .frame_valid (frame_valid),
        .frame       (frame),
        .bad_addr    (bad_addr)
    );

    spi_master_shift master_i
    (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frame       (frame),
        .bad_addr    (bad_addr),
        .miso        (miso),
        .ready       (ready),
        .op_done     (op_done),
        .busy        (busy),
        .cs          (cs),
        .mosi        (mosi),
        .xfer_end    (xfer_end),
        .resp        (resp)
    );

    spi_resp_out resp_out_i
    (
        .clk      (clk),
        .rst      (rst),
        .xfer_end (xfer_end),
        .resp     (resp),
        .done     (done),
        .err      (err),
        .rdata    (rdata)
    );

    spi_mem_slave slave_i
    (
        .clk     (clk),
        .rst     (rst),
        .cs      (cs),
        .mosi    (mosi),
        .miso    (miso),
        .ready   (ready),
        .op_done (op_done)
    );

endmodule

//--- hdl/spi_req_check.sv
`timescale 1ns/10ps

module spi_req_check
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  spi_mem_pkg::spi_req_t   req,
    input  logic                    busy,
    output logic                    frame_valid,
    output spi_mem_pkg::spi_frame_t frame,
    output logic                    bad_addr
);
    import spi_mem_pkg::*;

    logic accept;
    logic legal;

    // Starts that arrive while a transfer runs are dropped
    assign accept = start && !busy;
    assign legal  = req.addr < addr_w'(mem_depth);

    //////////////////////////////
    // Pulses
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            frame_valid <= 1'b0;
            bad_addr    <= 1'b0;
        end
        else
        begin
            // Exactly one of the two fires per accepted start
            frame_valid <= accept && legal;
            bad_addr    <= accept && !legal;
        end
    end

    //////////////////////////////
    // Frame payload
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            frame <= '{din: req.din, addr: req.addr, wr: req.wr};
        end
    end

endmodule

//--- hdl/spi_resp_out.sv
`timescale 1ns/10ps

module spi_resp_out
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           xfer_end,
    input  spi_mem_pkg::spi_resp_t         resp,
    output logic                           done,
    output logic                           err,
    output logic [spi_mem_pkg::data_w-1:0] rdata
);
    import spi_mem_pkg::*;

    logic rd_ok;

    // Only a clean read replaces the held byte
    assign rd_ok = xfer_end && resp.rd && !resp.err;

    //////////////////////////////
    // Completion
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            done  <= 1'b0;
            err   <= 1'b0;
            rdata <= '0;
        end
        else
        begin
            done <= xfer_end;
            err  <= xfer_end && resp.err;
            if (rd_ok)
            begin
                rdata <= resp.rdata;
            end
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f spi_mem.f --top-module spi_mem_tb -o spi_mem_sim
out=$(./obj_dir/spi_mem_sim +verilator+error+limit+100 || true)
echo "$out"
if echo "$out" | grep -qx "TEST RESULT: PASS"
then
    exit 0
fi
exit 1

//--- spi_mem.f
hdl/spi_mem_pkg.sv
hdl/spi_req_check.sv
hdl/spi_master_shift.sv
hdl/spi_resp_out.sv
hdl/spi_mem_slave.sv
hdl/spi_mem_top.sv
dv/spi_mem_chk.sv
dv/spi_mem_monitor.sv
dv/spi_mem_tb.sv
